//--- hw/controller_pkg.sv
// Receive payload types, descriptor layout and bus constants for the standby path
package controller_pkg;

  // Pin index of each protocol on the controller bus pairs
  localparam int unsigned BusI2c = 0;
  localparam int unsigned BusI3c = 1;

  localparam logic [6:0] I3cBroadcastAddr = 7'h7e;

  // Descriptor byte count saturates here
  localparam logic [6:0] ByteCountMax = 7'h7f;

  typedef logic [7:0] rx_byte_t;

  // One entry per matched write transfer
  typedef struct packed {
    logic [6:0] addr;
    logic       parity_err;
    logic       overflow;
    logic [6:0] byte_count;
  } rx_desc_t;

endpackage

//--- hw/bus_monitor.sv
// SCL/SDA synchronizer with START, STOP and SCL edge event detection
`timescale 1ns/1ns

module bus_monitor (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_o,
  output logic sda_o,
  output logic start_o,
  output logic stop_o,
  output logic scl_rise_o,
  output logic scl_fall_o
);

  // Bits 1:0 synchronize, bit 2 holds the previous level
  logic [2:0] scl_q;
  logic [2:0] sda_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scl_q <= 3'b111;
      sda_q <= 3'b111;
    end else begin
      scl_q <= {scl_q[1:0], scl_i};
      sda_q <= {sda_q[1:0], sda_i};
    end
  end

  assign scl_o = scl_q[2];
  assign sda_o = sda_q[2];

  // Registered events line up with scl_o and sda_o
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      start_o    <= 1'b0;
      stop_o     <= 1'b0;
      scl_rise_o <= 1'b0;
      scl_fall_o <= 1'b0;
    end else begin
      start_o    <= scl_q[1] & scl_q[2] & sda_q[2] & ~sda_q[1];
      stop_o     <= scl_q[1] & scl_q[2] & ~sda_q[2] & sda_q[1];
      scl_rise_o <= scl_q[1] & ~scl_q[2];
      scl_fall_o <= ~scl_q[1] & scl_q[2];
    end
  end

endmodule

//--- hw/controller_standby_i2c.sv
// I2C target engine receiving write transfers to the static address
`timescale 1ns/1ns

module controller_standby_i2c (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     ctrl_scl_i,
  input  logic                     ctrl_sda_i,
  input  logic                     enable_i,
  input  logic [6:0]               static_addr_i,
  input  logic                     rx_queue_wready_i,
  input  logic                     rx_desc_queue_wready_i,
  output logic                     ctrl_sda_o,
  output logic                     rx_queue_wvalid_o,
  output controller_pkg::rx_byte_t rx_queue_wdata_o,
  output logic                     rx_desc_queue_wvalid_o,
  output controller_pkg::rx_desc_t rx_desc_queue_wdata_o
);

  import controller_pkg::*;

  typedef enum logic [2:0] {
    Idle,
    Addr,
    AddrAck,
    Data,
    DataAck,
    Ignore
  } state_e;

  state_e     state_q;
  logic [2:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic [6:0] addr_q;
  logic [6:0] byte_cnt_q;
  logic       overflow_q;
  logic       sda;
  logic       start;
  logic       stop;
  logic       scl_rise;
  logic       scl_fall;
  logic [7:0] rx_bits;
  logic       in_xfer;

  bus_monitor u_bus_monitor (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .scl_i     (ctrl_scl_i),
    .sda_i     (ctrl_sda_i),
    .scl_o     (),
    .sda_o     (sda),
    .start_o   (start),
    .stop_o    (stop),
    .scl_rise_o(scl_rise),
    .scl_fall_o(scl_fall)
  );

  // Byte as completed by the current SCL rise
  assign rx_bits = {shift_q[6:0], sda};
  assign in_xfer = (state_q == Data) || (state_q == DataAck);

  always_ff @(posedge clk_i) begin
    // A disabled engine is held idle with SDA released
    if (!rst_n_i || !enable_i) begin
      state_q                <= Idle;
      bit_cnt_q              <= '0;
      byte_cnt_q             <= '0;
      overflow_q             <= 1'b0;
      ctrl_sda_o             <= 1'b1;
      rx_queue_wvalid_o      <= 1'b0;
      rx_desc_queue_wvalid_o <= 1'b0;
    end else begin
      rx_queue_wvalid_o      <= 1'b0;
      rx_desc_queue_wvalid_o <= 1'b0;
      if (start || stop) begin
        if (in_xfer && rx_desc_queue_wready_i) begin
          rx_desc_queue_wvalid_o <= 1'b1;
          rx_desc_queue_wdata_o  <= '{addr: addr_q, parity_err: 1'b0,
                                     overflow: overflow_q, byte_count: byte_cnt_q};
        end
        ctrl_sda_o <= 1'b1;
        bit_cnt_q  <= '0;
        byte_cnt_q <= '0;
        overflow_q <= 1'b0;
        state_q    <= start ? Addr : Idle;
      end else begin
        case (state_q)
          Addr: if (scl_rise) begin
            shift_q   <= rx_bits;
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (bit_cnt_q == 3'd7) begin
              addr_q  <= shift_q[6:0];
              // Write header to our address only
              state_q <= (shift_q[6:0] == static_addr_i && !sda) ? AddrAck : Ignore;
            end
          end
          AddrAck, DataAck: if (scl_fall) begin
            // Pull low after bit 8, release after bit 9
            ctrl_sda_o <= ~ctrl_sda_o;
            if (!ctrl_sda_o) begin
              state_q <= Data;
            end
          end
          Data: if (scl_rise) begin
            shift_q   <= rx_bits;
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (bit_cnt_q == 3'd7) begin
              if (rx_queue_wready_i) begin
                rx_queue_wvalid_o <= 1'b1;
                rx_queue_wdata_o  <= rx_bits;
              end else begin
                overflow_q <= 1'b1;
              end
              if (byte_cnt_q != ByteCountMax) begin
                byte_cnt_q <= byte_cnt_q + 7'd1;
              end
              state_q <= DataAck;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- hw/controller_standby_i3c.sv
// I3C SDR target engine with dynamic and broadcast address match and T-bit check
`timescale 1ns/1ns

module controller_standby_i3c (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     ctrl_scl_i,
  input  logic                     ctrl_sda_i,
  input  logic                     enable_i,
  input  logic [6:0]               dynamic_addr_i,
  input  logic                     rx_queue_wready_i,
  input  logic                     rx_desc_queue_wready_i,
  output logic                     ctrl_sda_o,
  output logic                     rx_queue_wvalid_o,
  output controller_pkg::rx_byte_t rx_queue_wdata_o,
  output logic                     rx_desc_queue_wvalid_o,
  output controller_pkg::rx_desc_t rx_desc_queue_wdata_o
);

  import controller_pkg::*;

  typedef enum logic [2:0] {
    Idle,
    Addr,
    AddrAck,
    Data,
    Ignore
  } state_e;

  state_e     state_q;
  logic [3:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic [6:0] addr_q;
  logic [6:0] byte_cnt_q;
  logic       overflow_q;
  logic       parity_err_q;
  logic       sda;
  logic       start;
  logic       stop;
  logic       scl_rise;
  logic       scl_fall;
  logic       addr_hit;

  bus_monitor u_bus_monitor (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .scl_i     (ctrl_scl_i),
    .sda_i     (ctrl_sda_i),
    .scl_o     (),
    .sda_o     (sda),
    .start_o   (start),
    .stop_o    (stop),
    .scl_rise_o(scl_rise),
    .scl_fall_o(scl_fall)
  );

  assign addr_hit = (shift_q[6:0] == dynamic_addr_i) || (shift_q[6:0] == I3cBroadcastAddr);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || !enable_i) begin
      state_q                <= Idle;
      bit_cnt_q              <= '0;
      byte_cnt_q             <= '0;
      overflow_q             <= 1'b0;
      parity_err_q           <= 1'b0;
      ctrl_sda_o             <= 1'b1;
      rx_queue_wvalid_o      <= 1'b0;
      rx_desc_queue_wvalid_o <= 1'b0;
    end else begin
      rx_queue_wvalid_o      <= 1'b0;
      rx_desc_queue_wvalid_o <= 1'b0;
      if (start || stop) begin
        if (state_q == Data && rx_desc_queue_wready_i) begin
          rx_desc_queue_wvalid_o <= 1'b1;
          rx_desc_queue_wdata_o  <= '{addr: addr_q, parity_err: parity_err_q,
                                     overflow: overflow_q, byte_count: byte_cnt_q};
        end
        ctrl_sda_o   <= 1'b1;
        bit_cnt_q    <= '0;
        byte_cnt_q   <= '0;
        overflow_q   <= 1'b0;
        parity_err_q <= 1'b0;
        state_q      <= start ? Addr : Idle;
      end else begin
        case (state_q)
          Addr: if (scl_rise) begin
            shift_q   <= {shift_q[6:0], sda};
            bit_cnt_q <= bit_cnt_q + 4'd1;
            if (bit_cnt_q == 4'd7) begin
              addr_q  <= shift_q[6:0];
              state_q <= (addr_hit && !sda) ? AddrAck : Ignore;
            end
          end
          AddrAck: if (scl_fall) begin
            ctrl_sda_o <= ~ctrl_sda_o;
            if (!ctrl_sda_o) begin
              bit_cnt_q <= '0;
              state_q   <= Data;
            end
          end
          Data: if (scl_rise) begin
            if (bit_cnt_q == 4'd8) begin
              // T-bit makes the nine bits odd
              if (!(^{shift_q, sda})) begin
                parity_err_q <= 1'b1;
              end
              if (rx_queue_wready_i) begin
                rx_queue_wvalid_o <= 1'b1;
                rx_queue_wdata_o  <= shift_q;
              end else begin
                overflow_q <= 1'b1;
              end
              if (byte_cnt_q != ByteCountMax) begin
                byte_cnt_q <= byte_cnt_q + 7'd1;
              end
              bit_cnt_q <= '0;
            end else begin
              shift_q   <= {shift_q[6:0], sda};
              bit_cnt_q <= bit_cnt_q + 4'd1;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- hw/controller_standby.sv
// Standby wrapper with the I2C and I3C target engines and their queue write mux
`timescale 1ns/1ns

module controller_standby (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     ctrl_scl_i[2],
  input  logic                     ctrl_sda_i[2],
  input  logic                     i2c_standby_en_i,
  input  logic                     i3c_standby_en_i,
  input  logic [6:0]               static_addr_i,
  input  logic [6:0]               dynamic_addr_i,
  input  logic                     rx_queue_wready_i,
  input  logic                     rx_desc_queue_wready_i,
  output logic                     ctrl_sda_o[2],
  output logic                     rx_queue_wvalid_o,
  output controller_pkg::rx_byte_t rx_queue_wdata_o,
  output logic                     rx_desc_queue_wvalid_o,
  output controller_pkg::rx_desc_t rx_desc_queue_wdata_o
);

  import controller_pkg::*;

  logic     i2c_rx_queue_wvalid;
  logic     i3c_rx_queue_wvalid;
  rx_byte_t i2c_rx_queue_wdata;
  rx_byte_t i3c_rx_queue_wdata;
  logic     i2c_rx_desc_queue_wvalid;
  logic     i3c_rx_desc_queue_wvalid;
  rx_desc_t i2c_rx_desc_queue_wdata;
  rx_desc_t i3c_rx_desc_queue_wdata;

  controller_standby_i2c u_i2c (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .ctrl_scl_i            (ctrl_scl_i[BusI2c]),
    .ctrl_sda_i            (ctrl_sda_i[BusI2c]),
    .enable_i              (i2c_standby_en_i),
    .static_addr_i         (static_addr_i),
    .rx_queue_wready_i     (rx_queue_wready_i),
    .rx_desc_queue_wready_i(rx_desc_queue_wready_i),
    .ctrl_sda_o            (ctrl_sda_o[BusI2c]),
    .rx_queue_wvalid_o     (i2c_rx_queue_wvalid),
    .rx_queue_wdata_o      (i2c_rx_queue_wdata),
    .rx_desc_queue_wvalid_o(i2c_rx_desc_queue_wvalid),
    .rx_desc_queue_wdata_o (i2c_rx_desc_queue_wdata)
  );

  controller_standby_i3c u_i3c (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .ctrl_scl_i            (ctrl_scl_i[BusI3c]),
    .ctrl_sda_i            (ctrl_sda_i[BusI3c]),
    .enable_i              (i3c_standby_en_i),
    .dynamic_addr_i        (dynamic_addr_i),
    .rx_queue_wready_i     (rx_queue_wready_i),
    .rx_desc_queue_wready_i(rx_desc_queue_wready_i),
    .ctrl_sda_o            (ctrl_sda_o[BusI3c]),
    .rx_queue_wvalid_o     (i3c_rx_queue_wvalid),
    .rx_queue_wdata_o      (i3c_rx_queue_wdata),
    .rx_desc_queue_wvalid_o(i3c_rx_desc_queue_wvalid),
    .rx_desc_queue_wdata_o (i3c_rx_desc_queue_wdata)
  );

  // I3C owns the queues when enabled, I2C otherwise
  always_comb begin
    if (i3c_standby_en_i) begin
      rx_queue_wvalid_o      = i3c_rx_queue_wvalid;
      rx_queue_wdata_o       = i3c_rx_queue_wdata;
      rx_desc_queue_wvalid_o = i3c_rx_desc_queue_wvalid;
      rx_desc_queue_wdata_o  = i3c_rx_desc_queue_wdata;
    end else begin
      rx_queue_wvalid_o      = i2c_rx_queue_wvalid;
      rx_queue_wdata_o       = i2c_rx_queue_wdata;
      rx_desc_queue_wvalid_o = i2c_rx_desc_queue_wvalid;
      rx_desc_queue_wdata_o  = i2c_rx_desc_queue_wdata;
    end
  end

endmodule

//--- hw/tti_queue.sv
// Synchronous FIFO with a type-parameter payload and a valid/ready read side
`timescale 1ns/1ns

module tti_queue #(
  parameter type         T     = logic [7:0],
  parameter int unsigned Depth = 8
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic wvalid_i,
  input  T     wdata_i,
  input  logic rready_i,
  output logic wready_o,
  output logic rvalid_o,
  output T     rdata_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  T                mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW:0]   count_q;
  logic            push;
  logic            pop;

  assign wready_o = (count_q != (PtrW + 1)'(Depth));
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem_q[rd_ptr_q];
  assign push     = wvalid_i & wready_o;
  assign pop      = rvalid_o & rready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

endmodule

//--- hw/standby_top.sv
// Standby receive top level with the wrapper, RX data queue and RX descriptor queue
`timescale 1ns/1ns

module standby_top #(
  parameter int unsigned DataDepth = 8,
  parameter int unsigned DescDepth = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     ctrl_scl_i[2],
  input  logic                     ctrl_sda_i[2],
  input  logic                     i2c_standby_en_i,
  input  logic                     i3c_standby_en_i,
  input  logic [6:0]               static_addr_i,
  input  logic [6:0]               dynamic_addr_i,
  input  logic                     rx_queue_rready_i,
  input  logic                     rx_desc_queue_rready_i,
  output logic                     ctrl_sda_o[2],
  output logic                     rx_queue_rvalid_o,
  output controller_pkg::rx_byte_t rx_queue_rdata_o,
  output logic                     rx_desc_queue_rvalid_o,
  output controller_pkg::rx_desc_t rx_desc_queue_rdata_o
);

  import controller_pkg::*;

  logic     rx_queue_wvalid;
  logic     rx_queue_wready;
  rx_byte_t rx_queue_wdata;
  logic     rx_desc_queue_wvalid;
  logic     rx_desc_queue_wready;
  rx_desc_t rx_desc_queue_wdata;

  controller_standby u_standby (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .ctrl_scl_i            (ctrl_scl_i),
    .ctrl_sda_i            (ctrl_sda_i),
    .i2c_standby_en_i      (i2c_standby_en_i),
    .i3c_standby_en_i      (i3c_standby_en_i),
    .static_addr_i         (static_addr_i),
    .dynamic_addr_i        (dynamic_addr_i),
    .rx_queue_wready_i     (rx_queue_wready),
    .rx_desc_queue_wready_i(rx_desc_queue_wready),
    .ctrl_sda_o            (ctrl_sda_o),
    .rx_queue_wvalid_o     (rx_queue_wvalid),
    .rx_queue_wdata_o      (rx_queue_wdata),
    .rx_desc_queue_wvalid_o(rx_desc_queue_wvalid),
    .rx_desc_queue_wdata_o (rx_desc_queue_wdata)
  );

  tti_queue #(
    .T    (rx_byte_t),
    .Depth(DataDepth)
  ) u_rx_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wvalid_i(rx_queue_wvalid),
    .wdata_i (rx_queue_wdata),
    .rready_i(rx_queue_rready_i),
    .wready_o(rx_queue_wready),
    .rvalid_o(rx_queue_rvalid_o),
    .rdata_o (rx_queue_rdata_o)
  );

  tti_queue #(
    .T    (rx_desc_t),
    .Depth(DescDepth)
  ) u_rx_desc_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wvalid_i(rx_desc_queue_wvalid),
    .wdata_i (rx_desc_queue_wdata),
    .rready_i(rx_desc_queue_rready_i),
    .wready_o(rx_desc_queue_wready),
    .rvalid_o(rx_desc_queue_rvalid_o),
    .rdata_o (rx_desc_queue_rdata_o)
  );

endmodule

//--- verif/standby_props.sv
// Bound assertions on the standby wrapper's queue writes and SDA outputs
`timescale 1ns/1ns

module standby_props (
  input logic clk_i,
  input logic rst_n_i,
  input logic i2c_standby_en_i,
  input logic i3c_standby_en_i,
  input logic ctrl_sda_o[2],
  input logic rx_queue_wvalid_o,
  input logic rx_queue_wready_i,
  input logic rx_desc_queue_wvalid_o,
  input logic rx_desc_queue_wready_i
);

  import controller_pkg::*;

  // Writes only into a queue with room
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_queue_wvalid_o |-> rx_queue_wready_i)
    else $error("data queue written while full");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_desc_queue_wvalid_o |-> rx_desc_queue_wready_i)
    else $error("descriptor queue written while full");

  // Disabled engines leave their bus alone
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !i2c_standby_en_i |-> ctrl_sda_o[BusI2c])
    else $error("disabled I2C engine pulls SDA");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !i3c_standby_en_i |-> ctrl_sda_o[BusI3c])
    else $error("disabled I3C engine pulls SDA");

  assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !rx_queue_wvalid_o && !rx_desc_queue_wvalid_o)
    else $error("queue write right after reset");

endmodule

bind controller_standby standby_props u_props (.*);

//--- verif/standby_tb.sv
// Directed testbench for standby_top with bus-master tasks, LFSR data and queue checks
`timescale 1ns/1ns

module standby_tb;

  import controller_pkg::*;

  localparam int unsigned DataDepth = 8;
  localparam int unsigned DescDepth = 4;
  localparam int          HalfClks  = 8;
  localparam int          Timeout   = 200;
  localparam logic [31:0] LfsrTaps  = 32'h80200003;
  localparam logic [6:0]  StaticAddr  = 7'h2a;
  localparam logic [6:0]  DynamicAddr = 7'h35;

  logic     clk;
  logic     rst_n;
  logic     scl [2];
  logic     sda_drv [2];
  logic     sda_line [2];
  logic     sda_out [2];
  logic     i2c_en;
  logic     i3c_en;
  logic     rx_queue_rready;
  logic     rx_desc_queue_rready;
  logic     rx_queue_rvalid;
  rx_byte_t rx_queue_rdata;
  logic     rx_desc_queue_rvalid;
  rx_desc_t rx_desc_queue_rdata;

  logic [31:0] lfsr_q;
  rx_byte_t    exp_bytes [$];
  int          value_errs;
  int          timeout_errs;

  // Open-drain bus, TB master and DUT target share each SDA line
  assign sda_line[0] = sda_drv[0] & sda_out[0];
  assign sda_line[1] = sda_drv[1] & sda_out[1];

  standby_top #(
    .DataDepth(DataDepth),
    .DescDepth(DescDepth)
  ) dut (
    .clk_i                 (clk),
    .rst_n_i               (rst_n),
    .ctrl_scl_i            (scl),
    .ctrl_sda_i            (sda_line),
    .i2c_standby_en_i      (i2c_en),
    .i3c_standby_en_i      (i3c_en),
    .static_addr_i         (StaticAddr),
    .dynamic_addr_i        (DynamicAddr),
    .rx_queue_rready_i     (rx_queue_rready),
    .rx_desc_queue_rready_i(rx_desc_queue_rready),
    .ctrl_sda_o            (sda_out),
    .rx_queue_rvalid_o     (rx_queue_rvalid),
    .rx_queue_rdata_o      (rx_queue_rdata),
    .rx_desc_queue_rvalid_o(rx_desc_queue_rvalid),
    .rx_desc_queue_rdata_o (rx_desc_queue_rdata)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LfsrTaps) : (s >> 1);
  endfunction

  task automatic rand_byte(output rx_byte_t v);
    for (int i = 0; i < 8; i++) begin
      v[i]   = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
    value_errs++;
  endtask

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic drive_scl(input int b, input logic v);
    @(posedge clk);
    if (b == 0) begin
      scl[0] <= v;
    end else begin
      scl[1] <= v;
    end
  endtask

  task automatic drive_sda(input int b, input logic v);
    @(posedge clk);
    if (b == 0) begin
      sda_drv[0] <= v;
    end else begin
      sda_drv[1] <= v;
    end
  endtask

  task automatic start_cond(input int b);
    drive_sda(b, 1'b1);
    wait_clks(HalfClks);
    drive_scl(b, 1'b1);
    wait_clks(HalfClks);
    drive_sda(b, 1'b0);
    wait_clks(HalfClks);
    drive_scl(b, 1'b0);
  endtask

  task automatic stop_cond(input int b);
    drive_sda(b, 1'b0);
    wait_clks(HalfClks);
    drive_scl(b, 1'b1);
    wait_clks(HalfClks);
    drive_sda(b, 1'b1);
    wait_clks(2 * HalfClks);
  endtask

  // Line level is taken in the middle of SCL high
  task automatic send_bit(input int b, input logic v, output logic line);
    drive_sda(b, v);
    wait_clks(HalfClks);
    drive_scl(b, 1'b1);
    wait_clks(HalfClks / 2);
    @(negedge clk);
    line = sda_line[b];
    wait_clks(HalfClks / 2);
    drive_scl(b, 1'b0);
  endtask

  task automatic send_byte(input int b, input rx_byte_t data, input logic ninth,
                           output logic line);
    logic unused;
    for (int i = 7; i >= 0; i--) begin
      send_bit(b, data[i], unused);
    end
    send_bit(b, ninth, line);
  endtask

  // Write of n random bytes, bad_t picks a byte whose T-bit is flipped
  task automatic run_write(input string name, input int b, input logic [6:0] addr,
                           input int n, input int bad_t);
    rx_byte_t data;
    logic     tbit;
    logic     line;
    start_cond(b);
    send_byte(b, {addr, 1'b0}, 1'b1, line);
    if (line !== 1'b0) begin
      report_mismatch({name, " address ack"}, 0, line);
    end
    for (int i = 0; i < n; i++) begin
      rand_byte(data);
      tbit = (b == 1) ? ~^data : 1'b1;
      if (i == bad_t) begin
        tbit = ~tbit;
      end
      send_byte(b, data, tbit, line);
      // I2C target pulls low, I3C target leaves the T-bit alone
      if (line !== ((b == 1) ? tbit : 1'b0)) begin
        report_mismatch({name, " ninth bit"}, (b == 1) ? tbit : 1'b0, line);
      end
      exp_bytes.push_back(data);
    end
    stop_cond(b);
  endtask

  task automatic pop_byte(input string name, output rx_byte_t v, output logic ok);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!rx_queue_rvalid && waited < Timeout) begin
      @(negedge clk);
      waited++;
    end
    ok = rx_queue_rvalid;
    v  = rx_queue_rdata;
    if (!ok) begin
      $display("%s: no data byte arrived within %0d clocks", name, Timeout);
      timeout_errs++;
    end else begin
      @(posedge clk);
      rx_queue_rready <= 1'b1;
      @(posedge clk);
      rx_queue_rready <= 1'b0;
    end
  endtask

  task automatic pop_desc(input string name, output rx_desc_t v, output logic ok);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!rx_desc_queue_rvalid && waited < Timeout) begin
      @(negedge clk);
      waited++;
    end
    ok = rx_desc_queue_rvalid;
    v  = rx_desc_queue_rdata;
    if (!ok) begin
      $display("%s: no descriptor arrived within %0d clocks", name, Timeout);
      timeout_errs++;
    end else begin
      @(posedge clk);
      rx_desc_queue_rready <= 1'b1;
      @(posedge clk);
      rx_desc_queue_rready <= 1'b0;
    end
  endtask

  task automatic check_rx(input string name, input rx_desc_t exp_desc);
    rx_byte_t got_byte;
    rx_byte_t exp_byte;
    rx_desc_t got_desc;
    logic     ok;
    while (exp_bytes.size() > 0) begin
      exp_byte = exp_bytes.pop_front();
      pop_byte(name, got_byte, ok);
      if (ok && got_byte !== exp_byte) begin
        report_mismatch({name, " data"}, exp_byte, got_byte);
      end
    end
    @(negedge clk);
    if (rx_queue_rvalid) begin
      $display("%s: data queue holds more bytes than were expected", name);
      value_errs++;
    end
    pop_desc(name, got_desc, ok);
    if (ok && got_desc !== exp_desc) begin
      report_mismatch({name, " descriptor"}, exp_desc, got_desc);
    end
  endtask

  task automatic set_mode(input logic use_i3c);
    @(posedge clk);
    i2c_en <= ~use_i3c;
    i3c_en <= use_i3c;
    wait_clks(4);
  endtask

  task automatic test_reset();
    @(negedge clk);
    if (rx_queue_rvalid || rx_desc_queue_rvalid) begin
      report_mismatch("reset rvalid", 0, {rx_queue_rvalid, rx_desc_queue_rvalid});
    end
    if (sda_out[0] !== 1'b1 || sda_out[1] !== 1'b1) begin
      report_mismatch("reset sda", 2'b11, {sda_out[1], sda_out[0]});
    end
  endtask

  task automatic test_i2c_write();
    set_mode(1'b0);
    run_write("i2c_write", 0, StaticAddr, 5, -1);
    check_rx("i2c_write", '{addr: StaticAddr, parity_err: 1'b0, overflow: 1'b0,
                            byte_count: 7'd5});
  endtask

  task automatic test_i2c_nack();
    logic line;
    set_mode(1'b0);
    start_cond(0);
    send_byte(0, {StaticAddr ^ 7'h01, 1'b0}, 1'b1, line);
    if (line !== 1'b1) begin
      report_mismatch("i2c_nack wrong address", 1, line);
    end
    stop_cond(0);
    start_cond(0);
    send_byte(0, {StaticAddr, 1'b1}, 1'b1, line);
    if (line !== 1'b1) begin
      report_mismatch("i2c_nack read header", 1, line);
    end
    stop_cond(0);
    wait_clks(10);
    @(negedge clk);
    if (rx_queue_rvalid || rx_desc_queue_rvalid) begin
      report_mismatch("i2c_nack queues", 0, {rx_queue_rvalid, rx_desc_queue_rvalid});
    end
  endtask

  task automatic test_i3c_write();
    set_mode(1'b1);
    run_write("i3c_write", 1, DynamicAddr, 4, -1);
    check_rx("i3c_write", '{addr: DynamicAddr, parity_err: 1'b0, overflow: 1'b0,
                            byte_count: 7'd4});
    run_write("i3c_broadcast", 1, I3cBroadcastAddr, 2, -1);
    check_rx("i3c_broadcast", '{addr: I3cBroadcastAddr, parity_err: 1'b0,
                                overflow: 1'b0, byte_count: 7'd2});
  endtask

  task automatic test_i3c_parity();
    set_mode(1'b1);
    run_write("i3c_parity", 1, DynamicAddr, 4, 2);
    check_rx("i3c_parity", '{addr: DynamicAddr, parity_err: 1'b1, overflow: 1'b0,
                             byte_count: 7'd4});
  endtask

  task automatic test_i2c_overflow();
    set_mode(1'b0);
    run_write("i2c_overflow", 0, StaticAddr, DataDepth + 3, -1);
    // Bytes past the queue depth are dropped on the floor
    while (exp_bytes.size() > DataDepth) begin
      void'(exp_bytes.pop_back());
    end
    check_rx("i2c_overflow", '{addr: StaticAddr, parity_err: 1'b0, overflow: 1'b1,
                               byte_count: 7'(DataDepth + 3)});
  endtask

  initial begin
    clk                  = 1'b0;
    rst_n                = 1'b0;
    scl[0]               = 1'b1;
    scl[1]               = 1'b1;
    sda_drv[0]           = 1'b1;
    sda_drv[1]           = 1'b1;
    i2c_en               = 1'b0;
    i3c_en               = 1'b0;
    rx_queue_rready      = 1'b0;
    rx_desc_queue_rready = 1'b0;
    lfsr_q               = 32'h1fd0c0ca;
    value_errs           = 0;
    timeout_errs         = 0;
    wait_clks(2);
    rst_n <= 1'b1;
    test_reset();
    test_i2c_write();
    test_i2c_nack();
    test_i3c_write();
    test_i3c_parity();
    test_i2c_overflow();
    $display("Value errors: %0d, timeout errors: %0d", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- i3c_standby.f
hw/controller_pkg.sv
hw/bus_monitor.sv
hw/controller_standby_i2c.sv
hw/controller_standby_i3c.sv
hw/controller_standby.sv
hw/tti_queue.sv
hw/standby_top.sv
verif/standby_props.sv
verif/standby_tb.sv
